/* logic/trace_pkg.sv */
package trace_pkg;

    localparam int xlen          = 64;              // data and address width
    localparam int opid_bits     = 7;
    localparam int rob_depth     = 1 << opid_bits;  // snapshot entries
    localparam int tag_bits      = 4;
    localparam int st_depth      = 1 << tag_bits;   // store records
    localparam int strb_bits     = 8;
    localparam int strb_ofs_bits = $clog2(strb_bits);

    typedef logic [xlen-1:0]      word_t;
    typedef logic [opid_bits-1:0] opid_t;
    typedef logic [tag_bits-1:0]  st_tag_t;
    typedef logic [strb_bits-1:0] strb_t;
    typedef logic [11:0]          csr_addr_t;
    typedef logic [3:0]           bytes_t;   // 0 to 8 bytes

    // supervisor aliases, moved up to machine mode
    localparam csr_addr_t csr_sstatus = 12'h100;
    localparam csr_addr_t csr_sie     = 12'h104;
    localparam csr_addr_t csr_sip     = 12'h144;
    localparam csr_addr_t s_to_m_ofs  = 12'h200;

    // user counters, moved down to machine counters
    localparam csr_addr_t csr_cycle   = 12'hc00;
    localparam csr_addr_t csr_time    = 12'hc01;
    localparam csr_addr_t csr_instret = 12'hc02;
    localparam csr_addr_t u_to_m_ofs  = 12'h100;

    typedef struct packed {
        word_t mstatus;
        word_t mtvec;
        word_t mcause;
        word_t mepc;
        word_t stvec;
        word_t sepc;
    } csr_set_t;

    typedef struct packed {
        logic    valid;
        st_tag_t tag;
        word_t   addr;
        word_t   wdata;
        strb_t   strb;
    } st_req_t;

    typedef struct packed {
        logic    valid;
        st_tag_t tag;
        logic    miss;
    } st_resp_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        logic [31:0] ir;
        csr_set_t    csrs;    // state before the op ran
    } commit_rec_t;

    typedef struct packed {
        bytes_t bytes;        // zero means no change
        word_t  addr;
        word_t  data;         // aligned to byte 0
    } mem_delta_t;

    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        word_t     value;
    } csr_delta_t;

endpackage

/* logic/csr_snapshot.sv */
`timescale 1ns/100ps

module csr_snapshot
    import trace_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     dec_valid,
    input  opid_t    dec_opid,
    input  csr_set_t csr_now,
    input  opid_t    cmt_opid,
    output csr_set_t snap_csrs
);

    csr_set_t snap_table [rob_depth];   // one entry per operation id
    logic     snap_we;

    // no capture while the core is held in reset
    assign snap_we = dec_valid & ~rst;

    always_ff @(posedge clk) begin
        if (snap_we) begin
            snap_table[dec_opid] <= csr_now;   // live state at decode
        end
    end

    // same-cycle decode of this id is not visible yet
    assign snap_csrs = snap_table[cmt_opid];

endmodule

/* logic/store_tracker.sv */
`timescale 1ns/100ps

module store_tracker
    import trace_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  st_req_t    st_req,
    input  st_resp_t   st_resp,
    output mem_delta_t st_hit_rec
);

    mem_delta_t               st_table [st_depth];   // indexed by cache tag
    logic [strb_ofs_bits-1:0] st_offset;
    mem_delta_t               new_rec;
    mem_delta_t               resp_rec;
    logic                     resp_hit;

    // lowest enabled byte lane
    always_comb begin
        st_offset = '0;
        for (int i = strb_bits - 1; i >= 0; i--) begin
            if (st_req.strb[i]) begin
                st_offset = strb_ofs_bits'(i);
            end
        end
    end

    always_comb begin
        new_rec.bytes = bytes_t'($countones(st_req.strb));
        new_rec.addr  = st_req.addr;
        new_rec.data  = st_req.wdata >> {st_offset, 3'b000};   // shift by whole bytes
    end

    always_ff @(posedge clk) begin
        if (st_req.valid && !rst) begin
            st_table[st_req.tag] <= new_rec;
        end
    end

    assign resp_rec = st_table[st_resp.tag];   // old record on same-tag write
    assign resp_hit = st_resp.valid & ~st_resp.miss;

    // a miss or an idle cycle reports no memory change
    always_comb begin
        st_hit_rec = resp_rec;
        if (!resp_hit) begin
            st_hit_rec.bytes = '0;
        end
    end

endmodule

/* logic/commit_tracer.sv */
`timescale 1ns/100ps

module commit_tracer
    import trace_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmt_valid,
    input  word_t       cmt_pc,
    input  logic [31:0] cmt_ir,
    input  csr_set_t    snap_csrs,
    input  mem_delta_t  st_hit_rec,
    input  logic        csr_we,
    input  csr_addr_t   csr_addr,
    input  word_t       csr_wdata,
    output commit_rec_t commit_rec,
    output mem_delta_t  mem_delta,
    output csr_delta_t  csr_delta
);

    csr_addr_t csr_addr_m;   // machine-mode address

    function automatic csr_addr_t fold_csr_addr(input csr_addr_t addr);
        csr_addr_t folded;
        case (addr)
            csr_sstatus, csr_sie, csr_sip: begin
                folded = addr + s_to_m_ofs;
            end
            csr_cycle, csr_time, csr_instret: begin
                folded = addr - u_to_m_ofs;
            end
            default: begin
                folded = addr;
            end
        endcase
        return folded;
    endfunction

    assign csr_addr_m = fold_csr_addr(csr_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            commit_rec.valid <= 1'b0;
            mem_delta.bytes  <= '0;
            csr_delta.valid  <= 1'b0;
        end else begin
            commit_rec.valid <= cmt_valid;
            mem_delta.bytes  <= st_hit_rec.bytes;   // already zero on miss
            csr_delta.valid  <= csr_we;
        end

        // payload follows the strobes every cycle
        commit_rec.pc   <= cmt_pc;
        commit_rec.ir   <= cmt_ir;
        commit_rec.csrs <= snap_csrs;
        mem_delta.addr  <= st_hit_rec.addr;
        mem_delta.data  <= st_hit_rec.data;
        csr_delta.addr  <= csr_addr_m;
        csr_delta.value <= csr_wdata;   // value passes unchanged
    end

endmodule

/* logic/trace_monitor.sv */
`timescale 1ns/100ps

module trace_monitor
    import trace_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        dec_valid,
    input  opid_t       dec_opid,
    input  csr_set_t    csr_now,     // live CSR state
    input  st_req_t     st_req,
    input  st_resp_t    st_resp,
    input  logic        cmt_valid,
    input  opid_t       cmt_opid,
    input  word_t       cmt_pc,
    input  logic [31:0] cmt_ir,
    input  logic        csr_we,
    input  csr_addr_t   csr_addr,
    input  word_t       csr_wdata,
    output commit_rec_t commit_rec,
    output mem_delta_t  mem_delta,
    output csr_delta_t  csr_delta
);

    csr_set_t   snap_csrs;    // entry for the committing op
    mem_delta_t st_hit_rec;   // masked store record

    csr_snapshot csr_snapshot_i (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec_opid  (dec_opid),
        .csr_now   (csr_now),
        .cmt_opid  (cmt_opid),
        .snap_csrs (snap_csrs)
    );

    store_tracker store_tracker_i (
        .clk        (clk),
        .rst        (rst),
        .st_req     (st_req),
        .st_resp    (st_resp),
        .st_hit_rec (st_hit_rec)
    );

    commit_tracer commit_tracer_i (
        .clk        (clk),
        .rst        (rst),
        .cmt_valid  (cmt_valid),
        .cmt_pc     (cmt_pc),
        .cmt_ir     (cmt_ir),
        .snap_csrs  (snap_csrs),
        .st_hit_rec (st_hit_rec),
        .csr_we     (csr_we),
        .csr_addr   (csr_addr),
        .csr_wdata  (csr_wdata),
        .commit_rec (commit_rec),
        .mem_delta  (mem_delta),
        .csr_delta  (csr_delta)
    );

endmodule

/* bench/trace_monitor_assertions.sv */
`timescale 1ns/100ps

module trace_monitor_assertions
    import trace_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        cmt_valid,
    input logic        csr_we,
    input commit_rec_t commit_rec,
    input mem_delta_t  mem_delta,
    input csr_delta_t  csr_delta
);

    int fail_count = 0;   // read by the testbench at the end

    commit_follows_strobe: assert property (@(posedge clk) disable iff (rst)
        commit_rec.valid == ($past(cmt_valid) && !$past(rst))
    ) else begin
        $error("commit record valid does not match the commit strobe one cycle earlier");
        fail_count++;
    end

    csr_write_follows_strobe: assert property (@(posedge clk) disable iff (rst)
        csr_delta.valid == ($past(csr_we) && !$past(rst))
    ) else begin
        $error("csr write record valid does not match csr_we one cycle earlier");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clk)
        $past(rst) |-> (!commit_rec.valid && mem_delta.bytes == 4'd0 && !csr_delta.valid)
    ) else begin
        $error("trace outputs active in the cycle after reset");
        fail_count++;
    end

endmodule

bind commit_tracer trace_monitor_assertions assertions_i (
    .clk        (clk),
    .rst        (rst),
    .cmt_valid  (cmt_valid),
    .csr_we     (csr_we),
    .commit_rec (commit_rec),
    .mem_delta  (mem_delta),
    .csr_delta  (csr_delta)
);

/* bench/trace_monitor_tb.sv */
`timescale 1ns/100ps

module trace_monitor_tb
    import trace_pkg::*;
;

    typedef struct packed {
        logic        dec_valid;
        opid_t       dec_opid;
        csr_set_t    csr_now;
        st_req_t     st_req;
        st_resp_t    st_resp;
        logic        cmt_valid;
        opid_t       cmt_opid;
        word_t       cmt_pc;
        logic [31:0] cmt_ir;
        logic        csr_we;
        csr_addr_t   csr_addr;
        word_t       csr_wdata;
        commit_rec_t exp_commit;   // outputs one cycle after the row
        mem_delta_t  exp_mem;
        csr_delta_t  exp_csr;
    } row_t;

    logic        clk;
    logic        rst;
    logic        dec_valid;
    opid_t       dec_opid;
    csr_set_t    csr_now;
    st_req_t     st_req;
    st_resp_t    st_resp;
    logic        cmt_valid;
    opid_t       cmt_opid;
    word_t       cmt_pc;
    logic [31:0] cmt_ir;
    logic        csr_we;
    csr_addr_t   csr_addr;
    word_t       csr_wdata;
    commit_rec_t commit_rec;
    mem_delta_t  mem_delta;
    csr_delta_t  csr_delta;

    row_t rows [23];         // idle row first and last
    int   check_errors = 0;
    int   timeouts     = 0;
    int   cycles       = 0;

    trace_monitor trace_monitor_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic csr_set_t rand_csrs();
        return {rand_word(), rand_word(), rand_word(),
                rand_word(), rand_word(), rand_word()};
    endfunction

    task automatic set_decode(input int i, input opid_t id, input csr_set_t csrs);
        rows[i].dec_valid = 1'b1;
        rows[i].dec_opid  = id;
        rows[i].csr_now   = csrs;
    endtask

    // commit strobe and the record expected from it
    task automatic set_commit(input int i, input opid_t id, input word_t pc,
                              input csr_set_t exp_csrs);
        rows[i].cmt_valid  = 1'b1;
        rows[i].cmt_opid   = id;
        rows[i].cmt_pc     = pc;
        rows[i].cmt_ir     = $urandom;
        rows[i].exp_commit = {1'b1, pc, rows[i].cmt_ir, exp_csrs};
    endtask

    task automatic build_table();
        csr_set_t  set_a, set_b, set_c, set_d;
        word_t     w1, w3, w7;
        csr_addr_t alias_in  [7] = '{12'h100, 12'h104, 12'h144, 12'hc00,
                                     12'hc01, 12'hc02, 12'h305};
        csr_addr_t alias_out [7] = '{12'h300, 12'h304, 12'h344, 12'hb00,
                                     12'hb01, 12'hb02, 12'h305};
        for (int i = 0; i < $size(rows); i++) begin
            rows[i] = '0;
        end
        set_a = rand_csrs();
        set_b = rand_csrs();
        set_c = rand_csrs();
        set_d = rand_csrs();
        w1    = rand_word();
        w3    = rand_word();
        w7    = rand_word();
        set_decode(1, 7'd5, set_a);
        set_decode(2, 7'd6, set_b);                  // live CSRs moved on
        set_commit(3, 7'd5, 64'h0000_0000_8000_0100, set_a);
        set_commit(4, 7'd6, 64'h0000_0000_8000_0104, set_b);
        set_decode(5, 7'd9, set_d);
        set_decode(6, 7'd9, set_c);
        set_commit(6, 7'd9, 64'h0000_0000_8000_0200, set_d);   // old entry wins
        set_commit(7, 7'd9, 64'h0000_0000_8000_0204, set_c);
        rows[8].st_req   = {1'b1, 4'd3, 64'h0000_0000_8000_1002, w3, 8'h0c};
        rows[9].st_resp  = {1'b1, 4'd3, 1'b0};
        rows[9].exp_mem  = {4'd2, 64'h0000_0000_8000_1002, w3 >> 16};
        rows[10].st_resp = {1'b1, 4'd3, 1'b1};       // miss, no change
        rows[11].st_resp = {1'b0, 4'd3, 1'b0};       // idle response on a stored tag
        rows[11].st_req  = {1'b1, 4'd1, 64'h0000_0000_8000_2000, w1, 8'hff};
        rows[12].st_req  = {1'b1, 4'd7, 64'h0000_0000_8000_3004, w7, 8'hf0};
        rows[13].st_resp = {1'b1, 4'd7, 1'b0};
        rows[13].exp_mem = {4'd4, 64'h0000_0000_8000_3004, w7 >> 32};
        rows[14].st_resp = {1'b1, 4'd1, 1'b0};
        rows[14].exp_mem = {4'd8, 64'h0000_0000_8000_2000, w1};
        for (int k = 0; k < 7; k++) begin
            rows[15 + k].csr_we    = 1'b1;
            rows[15 + k].csr_addr  = alias_in[k];
            rows[15 + k].csr_wdata = rand_word();
            rows[15 + k].exp_csr   = {1'b1, alias_out[k], rows[15 + k].csr_wdata};
        end
    endtask

    task automatic apply_row(input row_t r);
        dec_valid = r.dec_valid;
        dec_opid  = r.dec_opid;
        csr_now   = r.csr_now;
        st_req    = r.st_req;
        st_resp   = r.st_resp;
        cmt_valid = r.cmt_valid;
        cmt_opid  = r.cmt_opid;
        cmt_pc    = r.cmt_pc;
        cmt_ir    = r.cmt_ir;
        csr_we    = r.csr_we;
        csr_addr  = r.csr_addr;
        csr_wdata = r.csr_wdata;
    endtask

    task automatic compare_value(input string name, input logic [511:0] exp,
                                 input logic [511:0] act);
        if (exp !== act) begin
            $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    // payload only matters while its valid or bytes field is set
    task automatic check_row(input row_t r);
        compare_value("commit_rec.valid", 512'(r.exp_commit.valid), 512'(commit_rec.valid));
        if (r.exp_commit.valid) begin
            compare_value("commit_rec.pc", 512'(r.exp_commit.pc), 512'(commit_rec.pc));
            compare_value("commit_rec.ir", 512'(r.exp_commit.ir), 512'(commit_rec.ir));
            compare_value("commit_rec.csrs", 512'(r.exp_commit.csrs), 512'(commit_rec.csrs));
        end
        compare_value("mem_delta.bytes", 512'(r.exp_mem.bytes), 512'(mem_delta.bytes));
        if (r.exp_mem.bytes != 4'd0) begin
            compare_value("mem_delta.addr", 512'(r.exp_mem.addr), 512'(mem_delta.addr));
            compare_value("mem_delta.data", 512'(r.exp_mem.data), 512'(mem_delta.data));
        end
        compare_value("csr_delta.valid", 512'(r.exp_csr.valid), 512'(csr_delta.valid));
        if (r.exp_csr.valid) begin
            compare_value("csr_delta.addr", 512'(r.exp_csr.addr), 512'(csr_delta.addr));
            compare_value("csr_delta.value", 512'(r.exp_csr.value), 512'(csr_delta.value));
        end
    endtask

    task automatic end_run();
        int assert_fails;
        int total;
        assert_fails = trace_monitor_i.commit_tracer_i.assertions_i.fail_count;
        total        = check_errors + timeouts + assert_fails;
        $display("errors: %0d (value checks %0d, timeouts %0d, assertions %0d)",
                 total, check_errors, timeouts, assert_fails);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(18));
        rst = 1'b1;
        apply_row('0);
        cmt_valid = 1'b1;              // strobes held during reset are dropped
        csr_we    = 1'b1;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_row('0);                 // outputs idle straight after reset
        for (int i = 0; i < $size(rows); i++) begin
            apply_row(rows[i]);
            @(negedge clk);
            check_row(rows[i]);
        end
        end_run();
    end

    initial begin
        int limit;
        limit = $size(rows) + 5 + 20;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the stimulus table did not finish within %0d cycles", limit);
        timeouts++;
        end_run();
    end

endmodule

/* files.f */
logic/trace_pkg.sv
logic/csr_snapshot.sv
logic/store_tracker.sv
logic/commit_tracer.sv
logic/trace_monitor.sv
bench/trace_monitor_assertions.sv
bench/trace_monitor_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP      = trace_monitor_tb
FILELIST = files.f
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | awk '{ print } /test passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
